// ==== design/reorder_buffer.sv ====
/*
  reorder buffer top level
  32 entries, two wide dispatch, two CDBs, two wide in-order commit
*/
`timescale 1ns/1ps

module reorder_buffer (
  input  logic                            clock,
  input  logic                            reset,

  // dispatch
  input  logic [1:0]                      dispatch_valid,
  input  logic [rob_pkg::reg_width-1:0]   dispatch_dest0,
  input  logic [rob_pkg::reg_width-1:0]   dispatch_dest1,
  output logic                            dispatch_ready,
  output rob_pkg::rob_tag_u               dispatch_tag0,
  output rob_pkg::rob_tag_u               dispatch_tag1,

  // common data buses
  input  rob_pkg::rob_tag_u               cdb0_tag,
  input  rob_pkg::rob_tag_u               cdb1_tag,
  input  logic [rob_pkg::value_width-1:0] cdb0_value,
  input  logic [rob_pkg::value_width-1:0] cdb1_value,

  // operand reads
  input  rob_pkg::rob_tag_u               read_tag0,
  input  rob_pkg::rob_tag_u               read_tag1,
  output logic [rob_pkg::value_width-1:0] read_value0,
  output logic [rob_pkg::value_width-1:0] read_value1,

  // commit to the register file
  input  logic                            retire_ready,
  output logic [1:0]                      retire_valid,
  output logic [rob_pkg::reg_width-1:0]   retire_dest0,
  output logic [rob_pkg::reg_width-1:0]   retire_dest1,
  output logic [rob_pkg::value_width-1:0] retire_value0,
  output logic [rob_pkg::value_width-1:0] retire_value1,
  output rob_pkg::rob_tag_u               retire_tag0,
  output rob_pkg::rob_tag_u               retire_tag1,

  output logic                            rob_empty
);

  rob_alloc_if  alloc_link ();
  rob_commit_if commit_link ();

  rob_alloc u_alloc (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_dest0 (dispatch_dest0),
    .dispatch_dest1 (dispatch_dest1),
    .dispatch_ready (dispatch_ready),
    .dispatch_tag0  (dispatch_tag0),
    .dispatch_tag1  (dispatch_tag1),
    .wr             (alloc_link.alloc)
  );

  rob_entry_array u_entries (
    .clock       (clock),
    .reset       (reset),
    .cdb0_tag    (cdb0_tag),
    .cdb1_tag    (cdb1_tag),
    .cdb0_value  (cdb0_value),
    .cdb1_value  (cdb1_value),
    .read_tag0   (read_tag0),
    .read_tag1   (read_tag1),
    .read_value0 (read_value0),
    .read_value1 (read_value1),
    .rob_empty   (rob_empty),
    .wr          (alloc_link.storage),
    .cm          (commit_link.storage)
  );

  rob_commit u_commit (
    .clock         (clock),
    .reset         (reset),
    .retire_ready  (retire_ready),
    .retire_valid  (retire_valid),
    .retire_dest0  (retire_dest0),
    .retire_dest1  (retire_dest1),
    .retire_value0 (retire_value0),
    .retire_value1 (retire_value1),
    .retire_tag0   (retire_tag0),
    .retire_tag1   (retire_tag1),
    .cm            (commit_link.commit)
  );

endmodule

// ==== design/rob_alloc.sv ====
/*
  reorder buffer dispatch stage
  owns the tail pointer, the dispatch handshake and tag assignment
*/
`timescale 1ns/1ps

module rob_alloc (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [1:0]                    dispatch_valid,
  input  logic [rob_pkg::reg_width-1:0] dispatch_dest0,
  input  logic [rob_pkg::reg_width-1:0] dispatch_dest1,
  output logic                          dispatch_ready,
  output rob_pkg::rob_tag_u             dispatch_tag0,
  output rob_pkg::rob_tag_u             dispatch_tag1,
  rob_alloc_if.alloc                    wr
);

  logic [rob_pkg::index_width-1:0] tail;
  logic [rob_pkg::index_width-1:0] tail_plus_one;
  logic [rob_pkg::index_width-1:0] tail_plus_two;
  logic                            take0;
  logic                            take1;
  logic [1:0]                      take_count;

  // five bit adds wrap at the buffer size
  assign tail_plus_one = tail + rob_pkg::index_width'(1);
  assign tail_plus_two = tail + rob_pkg::index_width'(2);

  // one ready for both slots, low once fewer than two entries are free
  assign dispatch_ready = wr.slots_free;
  assign take0 = dispatch_valid[0] && dispatch_ready;
  assign take1 = dispatch_valid[1] && dispatch_ready;
  assign take_count = {1'b0, take0} + {1'b0, take1};

  ////////////////////////////////////////
  // storage writes
  ////////////////////////////////////////

  // a lone slot 1 instruction lands in the first free entry
  assign wr.write_en[0] = take0 || take1;
  assign wr.write_en[1] = take0 && take1;
  assign wr.write_index0 = tail_plus_one;
  assign wr.write_index1 = tail_plus_two;
  assign wr.write_dest0 = take0 ? dispatch_dest0 : dispatch_dest1;
  assign wr.write_dest1 = dispatch_dest1;

  // tags are the entry index with the spare bits clear
  always_comb
  begin
    dispatch_tag0.raw = rob_pkg::tag_null;
    dispatch_tag1.raw = rob_pkg::tag_null;
    if (take0)
    begin
      dispatch_tag0.fields.spare = '0;
      dispatch_tag0.fields.index = tail_plus_one;
    end
    if (take1)
    begin
      dispatch_tag1.fields.spare = '0;
      dispatch_tag1.fields.index = take0 ? tail_plus_two : tail_plus_one;
    end
  end

  // tail sits one behind the next free entry, so the first tag is 0
  always_ff @(posedge clock)
  begin
    if (reset)
      tail <= rob_pkg::index_width'(rob_pkg::rob_entries - 1);
    else
      tail <= tail + rob_pkg::index_width'(take_count);
  end

endmodule

// ==== design/rob_commit.sv ====
/*
  reorder buffer commit stage
  owns the head pointer, retires up to two entries in order
*/
`timescale 1ns/1ps

module rob_commit (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            retire_ready,
  output logic [1:0]                      retire_valid,
  output logic [rob_pkg::reg_width-1:0]   retire_dest0,
  output logic [rob_pkg::reg_width-1:0]   retire_dest1,
  output logic [rob_pkg::value_width-1:0] retire_value0,
  output logic [rob_pkg::value_width-1:0] retire_value1,
  output rob_pkg::rob_tag_u               retire_tag0,
  output rob_pkg::rob_tag_u               retire_tag1,
  rob_commit_if.commit                    cm
);

  logic [rob_pkg::index_width-1:0] head;
  logic [rob_pkg::index_width-1:0] head_plus_one;
  logic [1:0]                      retire_count;

  assign head_plus_one = head + rob_pkg::index_width'(1);
  assign cm.head_index = head;
  assign cm.next_index = head_plus_one;

  // second slot only with the first, keeps program order
  assign retire_valid[0] = cm.done[0];
  assign retire_valid[1] = cm.done[0] && cm.done[1];

  // nothing leaves while the register file stalls
  assign cm.free_en = retire_ready ? retire_valid : 2'b00;
  assign retire_count = {1'b0, cm.free_en[0]} + {1'b0, cm.free_en[1]};

  ////////////////////////////////////////
  // commit port
  ////////////////////////////////////////

  assign retire_dest0 = retire_valid[0] ? cm.dest0 : rob_pkg::zero_reg;
  assign retire_dest1 = retire_valid[1] ? cm.dest1 : rob_pkg::zero_reg;
  assign retire_value0 = retire_valid[0] ? cm.value0 : '0;
  assign retire_value1 = retire_valid[1] ? cm.value1 : '0;

  always_comb
  begin
    retire_tag0.raw = rob_pkg::tag_null;
    retire_tag1.raw = rob_pkg::tag_null;
    if (retire_valid[0])
    begin
      retire_tag0.fields.spare = '0;
      retire_tag0.fields.index = head;
    end
    if (retire_valid[1])
    begin
      retire_tag1.fields.spare = '0;
      retire_tag1.fields.index = head_plus_one;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      head <= '0;
    else
      head <= head + rob_pkg::index_width'(retire_count);
  end

endmodule

// ==== design/rob_entry_array.sv ====
/*
  reorder buffer entry storage
  per entry state, destination and result, with CDB completion,
  operand reads by tag and empty detection
*/
`timescale 1ns/1ps

module rob_entry_array (
  input  logic                            clock,
  input  logic                            reset,
  input  rob_pkg::rob_tag_u               cdb0_tag,
  input  rob_pkg::rob_tag_u               cdb1_tag,
  input  logic [rob_pkg::value_width-1:0] cdb0_value,
  input  logic [rob_pkg::value_width-1:0] cdb1_value,
  input  rob_pkg::rob_tag_u               read_tag0,
  input  rob_pkg::rob_tag_u               read_tag1,
  output logic [rob_pkg::value_width-1:0] read_value0,
  output logic [rob_pkg::value_width-1:0] read_value1,
  output logic                            rob_empty,
  rob_alloc_if.storage                    wr,
  rob_commit_if.storage                   cm
);

  logic [1:0]                      entry_state [rob_pkg::rob_entries];
  logic [rob_pkg::reg_width-1:0]   entry_dest  [rob_pkg::rob_entries];
  logic [rob_pkg::value_width-1:0] entry_value [rob_pkg::rob_entries];
  logic [rob_pkg::rob_entries-1:0] entry_is_empty;

  ////////////////////////////////////////
  // entries
  ////////////////////////////////////////

  for (genvar i = 0; i < rob_pkg::rob_entries; i++)
  begin : g_entry
    logic                            hit_write0;
    logic                            hit_write1;
    logic                            hit_write;
    logic                            hit_free;
    logic                            hit_cdb0;
    logic                            hit_cdb1;
    logic [1:0]                      state_q;
    logic [rob_pkg::reg_width-1:0]   dest_q;
    logic [rob_pkg::value_width-1:0] value_q;

    assign hit_write0 = wr.write_en[0] && (wr.write_index0 == rob_pkg::index_width'(i));
    assign hit_write1 = wr.write_en[1] && (wr.write_index1 == rob_pkg::index_width'(i));
    assign hit_write  = hit_write0 || hit_write1;

    assign hit_free = (cm.free_en[0] && (cm.head_index == rob_pkg::index_width'(i)))
                   || (cm.free_en[1] && (cm.next_index == rob_pkg::index_width'(i)));

    // whole tag word must match, so tag_null never completes anything
    assign hit_cdb0 = (cdb0_tag.raw == rob_pkg::tag_width'(i));
    assign hit_cdb1 = (cdb1_tag.raw == rob_pkg::tag_width'(i));

    // dispatch beats completion, CDB 0 beats CDB 1
    always_ff @(posedge clock)
    begin
      if (reset)
        state_q <= rob_pkg::state_empty;
      else if (hit_write)
        state_q <= rob_pkg::state_inuse;
      else if (hit_free)
        state_q <= rob_pkg::state_empty;
      else if (hit_cdb0 || hit_cdb1)
        state_q <= rob_pkg::state_complete;
    end

    always_ff @(posedge clock)
    begin
      if (hit_write)
        dest_q <= hit_write0 ? wr.write_dest0 : wr.write_dest1;
      if (!hit_write && hit_cdb0)
        value_q <= cdb0_value;
      else if (!hit_write && hit_cdb1)
        value_q <= cdb1_value;
    end

    assign entry_state[i] = state_q;
    assign entry_dest[i] = dest_q;
    assign entry_value[i] = value_q;
    assign entry_is_empty[i] = (state_q == rob_pkg::state_empty);
  end

  ////////////////////////////////////////
  // lookups
  ////////////////////////////////////////

  // both entries after the tail must be free to accept a pair
  assign wr.slots_free = entry_is_empty[wr.write_index0] && entry_is_empty[wr.write_index1];

  // operand reads address by index only
  assign read_value0 = entry_value[read_tag0.fields.index];
  assign read_value1 = entry_value[read_tag1.fields.index];

  assign cm.done[0] = (entry_state[cm.head_index] == rob_pkg::state_complete);
  assign cm.done[1] = (entry_state[cm.next_index] == rob_pkg::state_complete);
  assign cm.dest0 = entry_dest[cm.head_index];
  assign cm.dest1 = entry_dest[cm.next_index];
  assign cm.value0 = entry_value[cm.head_index];
  assign cm.value1 = entry_value[cm.next_index];

  assign rob_empty = &entry_is_empty;

endmodule

// ==== design/rob_if.sv ====
/*
  reorder buffer internal links
  allocation to storage, and commit to storage
*/
`timescale 1ns/1ps

// dispatch writes into the entry array
interface rob_alloc_if;

  logic [1:0]                      write_en;
  logic [rob_pkg::index_width-1:0] write_index0;
  logic [rob_pkg::index_width-1:0] write_index1;
  logic [rob_pkg::reg_width-1:0]   write_dest0;
  logic [rob_pkg::reg_width-1:0]   write_dest1;
  // both target entries are empty
  logic                            slots_free;

  modport alloc (output write_en, write_index0, write_index1, write_dest0, write_dest1,
                 input slots_free);
  modport storage (input write_en, write_index0, write_index1, write_dest0, write_dest1,
                   output slots_free);

endinterface

// head lookups and entry release
interface rob_commit_if;

  logic [rob_pkg::index_width-1:0] head_index;
  logic [rob_pkg::index_width-1:0] next_index;
  logic [1:0]                      free_en;
  logic [1:0]                      done;
  logic [rob_pkg::reg_width-1:0]   dest0;
  logic [rob_pkg::reg_width-1:0]   dest1;
  logic [rob_pkg::value_width-1:0] value0;
  logic [rob_pkg::value_width-1:0] value1;

  modport commit (output head_index, next_index, free_en,
                  input done, dest0, dest1, value0, value1);
  modport storage (input head_index, next_index, free_en,
                   output done, dest0, dest1, value0, value1);

endinterface

// ==== design/rob_pkg.sv ====
/*
  reorder buffer shared definitions
  widths, entry state codes, null values and the tag word layout
*/
package rob_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  localparam int rob_entries = 32;
  localparam int index_width = 5;
  localparam int tag_width   = 8;
  localparam int reg_width   = 5;
  localparam int value_width = 64;

  // upper tag bits that do not address an entry
  localparam int spare_width = tag_width - index_width;

  ////////////////////////////////////////
  // null values
  ////////////////////////////////////////

  // architectural zero register, shown on an idle commit slot
  localparam logic [reg_width-1:0] zero_reg = 5'd31;

  // all ones never matches an entry index
  localparam logic [tag_width-1:0] tag_null = 8'hff;

  ////////////////////////////////////////
  // entry state codes
  ////////////////////////////////////////

  localparam logic [1:0] state_empty    = 2'b00;
  localparam logic [1:0] state_inuse    = 2'b01;
  localparam logic [1:0] state_complete = 2'b10;

  // one tag word, compared whole or split to address storage
  typedef union packed {
    logic [tag_width-1:0] raw;
    struct packed {
      logic [spare_width-1:0] spare;
      logic [index_width-1:0] index;
    } fields;
  } rob_tag_u;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the reorder buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_reorder_buffer -f tb.f -o sim_rob
./obj_dir/sim_rob > sim.log 2>&1
cat sim.log
if grep -q ">>> FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished cleanly"

// ==== tb.f ====
design/rob_pkg.sv
design/rob_if.sv
design/rob_alloc.sv
design/rob_entry_array.sv
design/rob_commit.sv
design/reorder_buffer.sv
tb/rob_chk.sv
tb/tb_reorder_buffer.sv

// ==== tb/rob_chk.sv ====
/*
  reorder buffer port assertions
  bound to the top level
*/
`timescale 1ns/1ps

module rob_chk (
  input logic              clock,
  input logic              reset,
  input logic [1:0]        dispatch_valid,
  input logic              dispatch_ready,
  input rob_pkg::rob_tag_u dispatch_tag0,
  input rob_pkg::rob_tag_u dispatch_tag1,
  input logic [1:0]        retire_valid,
  input logic              rob_empty
);

  // second commit slot never runs ahead of the first
  a_commit_order: assert property (@(posedge clock) disable iff (reset)
    retire_valid[1] |-> retire_valid[0])
    else $error("retire_valid slot 1 without slot 0");

  a_empty_idle: assert property (@(posedge clock) disable iff (reset)
    !(rob_empty && retire_valid[0]))
    else $error("rob_empty while an entry is ready to retire");

  a_tag0_null: assert property (@(posedge clock) disable iff (reset)
    !(dispatch_valid[0] && dispatch_ready) |-> (dispatch_tag0.raw == rob_pkg::tag_null))
    else $error("unaccepted dispatch slot 0 shows a tag");

  a_tag1_null: assert property (@(posedge clock) disable iff (reset)
    !(dispatch_valid[1] && dispatch_ready) |-> (dispatch_tag1.raw == rob_pkg::tag_null))
    else $error("unaccepted dispatch slot 1 shows a tag");

endmodule

bind reorder_buffer rob_chk u_chk (
  .clock          (clock),
  .reset          (reset),
  .dispatch_valid (dispatch_valid),
  .dispatch_ready (dispatch_ready),
  .dispatch_tag0  (dispatch_tag0),
  .dispatch_tag1  (dispatch_tag1),
  .retire_valid   (retire_valid),
  .rob_empty      (rob_empty)
);

// ==== tb/tb_reorder_buffer.sv ====
/*
  reorder buffer testbench
  directed tests checked against a queue model of dispatched entries
*/
`timescale 1ns/1ps

module tb_reorder_buffer;

  logic                    clock;
  logic                    reset;
  logic [1:0]              dispatch_valid;
  logic [4:0]              dispatch_dest0;
  logic [4:0]              dispatch_dest1;
  logic                    dispatch_ready;
  rob_pkg::rob_tag_u       dispatch_tag0;
  rob_pkg::rob_tag_u       dispatch_tag1;
  rob_pkg::rob_tag_u       cdb0_tag;
  rob_pkg::rob_tag_u       cdb1_tag;
  logic [63:0]             cdb0_value;
  logic [63:0]             cdb1_value;
  rob_pkg::rob_tag_u       read_tag0;
  rob_pkg::rob_tag_u       read_tag1;
  logic [63:0]             read_value0;
  logic [63:0]             read_value1;
  logic                    retire_ready;
  logic [1:0]              retire_valid;
  logic [4:0]              retire_dest0;
  logic [4:0]              retire_dest1;
  logic [63:0]             retire_value0;
  logic [63:0]             retire_value1;
  rob_pkg::rob_tag_u       retire_tag0;
  rob_pkg::rob_tag_u       retire_tag1;
  logic                    rob_empty;

  int          errors;
  int          checks;
  bit          hung;
  // model of live tags in program order and their contents
  logic [4:0]  next_tag;
  logic [4:0]  order_q [$];
  logic [4:0]  model_dest [32];
  logic [63:0] model_value [32];
  bit          model_done [32];

  reorder_buffer dut (.*);

  initial clock = 1'b0;
  always #2 clock = ~clock;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, expected);
    end
  endtask

  // every task starts and ends 1 ns after a rising edge
  task automatic next_cycle;
    @(posedge clock);
    #1;
  endtask

  task automatic record_entry(input logic [4:0] dest);
    order_q.push_back(next_tag);
    model_dest[next_tag] = dest;
    model_done[next_tag] = 1'b0;
    next_tag = next_tag + 5'd1;
  endtask

  task automatic dispatch(input logic [1:0] slots);
    int wait_count;
    wait_count = 0;
    while (!dispatch_ready && wait_count < 50)
    begin
      next_cycle();
      wait_count++;
    end
    if (!dispatch_ready)
    begin
      errors++;
      hung = 1'b1;
      $display("timeout at %0t ns: dispatch_ready never came back", $time);
    end
    else
    begin
      dispatch_valid = slots;
      dispatch_dest0 = 5'($urandom % 31);
      dispatch_dest1 = 5'($urandom % 31);
      #1;
      if (slots[0])
      begin
        check("dispatch_tag0", 64'(dispatch_tag0.raw), 64'({3'b000, next_tag}));
        record_entry(dispatch_dest0);
      end
      else
        check("dispatch_tag0 idle", 64'(dispatch_tag0.raw), 64'(rob_pkg::tag_null));
      if (slots[1])
      begin
        check("dispatch_tag1", 64'(dispatch_tag1.raw), 64'({3'b000, next_tag}));
        record_entry(dispatch_dest1);
      end
      else
        check("dispatch_tag1 idle", 64'(dispatch_tag1.raw), 64'(rob_pkg::tag_null));
      next_cycle();
      dispatch_valid = 2'b00;
    end
  endtask

  task automatic check_slot(input string slot, input bit active, input logic [4:0] index,
                            input logic [7:0] tag_raw, input logic [4:0] dest,
                            input logic [63:0] value);
    if (active)
    begin
      check({"retire_tag", slot}, 64'(tag_raw), 64'({3'b000, index}));
      check({"retire_dest", slot}, 64'(dest), 64'(model_dest[index]));
      check({"retire_value", slot}, value, model_value[index]);
    end
    else
    begin
      check({"idle retire_tag", slot}, 64'(tag_raw), 64'(rob_pkg::tag_null));
      check({"idle retire_dest", slot}, 64'(dest), 64'(rob_pkg::zero_reg));
      check({"idle retire_value", slot}, value, 64'd0);
    end
  endtask

  // head of the model queue decides what the commit port must show
  task automatic check_commit(input bit pop);
    bit exp0;
    bit exp1;
    exp0 = (order_q.size() > 0) && model_done[order_q[0]];
    exp1 = exp0 && (order_q.size() > 1) && model_done[order_q[1]];
    check("rob_empty", 64'(rob_empty), 64'(order_q.size() == 0));
    check("retire_valid", 64'(retire_valid), 64'({exp1, exp0}));
    check_slot("0", exp0, order_q[0], retire_tag0.raw, retire_dest0, retire_value0);
    check_slot("1", exp1, order_q[1], retire_tag1.raw, retire_dest1, retire_value1);
    if (pop && exp0)
      void'(order_q.pop_front());
    if (pop && exp1)
      void'(order_q.pop_front());
  endtask

  // tag_b below zero leaves CDB 1 idle
  task automatic complete(input int tag_a, input int tag_b);
    cdb0_tag.raw = 8'(tag_a);
    cdb0_value = {$urandom, $urandom};
    model_value[tag_a[4:0]] = cdb0_value;
    model_done[tag_a[4:0]] = 1'b1;
    if (tag_b >= 0)
    begin
      cdb1_tag.raw = 8'(tag_b);
      cdb1_value = {$urandom, $urandom};
      model_value[tag_b[4:0]] = cdb1_value;
      model_done[tag_b[4:0]] = 1'b1;
    end
    next_cycle();
    cdb0_tag.raw = rob_pkg::tag_null;
    cdb1_tag.raw = rob_pkg::tag_null;
    #1;
    check_commit(1'b0);
    next_cycle();
  endtask

  // spare tag bits are random and must not matter
  task automatic read_check(input logic [4:0] tag_a, input logic [4:0] tag_b);
    read_tag0.fields.spare = 3'($urandom);
    read_tag0.fields.index = tag_a;
    read_tag1.fields.spare = 3'($urandom);
    read_tag1.fields.index = tag_b;
    #1;
    check("read_value0", read_value0, model_value[tag_a]);
    check("read_value1", read_value1, model_value[tag_b]);
    next_cycle();
  endtask

  task automatic drain;
    int wait_count;
    wait_count = 0;
    retire_ready = 1'b1;
    while (order_q.size() > 0 && wait_count < 100)
    begin
      #1;
      check_commit(1'b1);
      next_cycle();
      wait_count++;
    end
    retire_ready = 1'b0;
    if (order_q.size() > 0)
    begin
      errors++;
      hung = 1'b1;
      $display("timeout at %0t ns: completed entries never retired", $time);
    end
    #1;
    check("rob_empty after drain", 64'(rob_empty), 64'd1);
    next_cycle();
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_reset;
    #1;
    check("rob_empty after reset", 64'(rob_empty), 64'd1);
    check("dispatch_ready after reset", 64'(dispatch_ready), 64'd1);
    check("retire_valid after reset", 64'(retire_valid), 64'd0);
    next_cycle();
  endtask

  task automatic test_tag_order;
    dispatch(2'b11);
    dispatch(2'b10);
    dispatch(2'b01);
    dispatch(2'b11);
  endtask

  // tags 0..5 finish out of order with both buses busy in places
  task automatic test_out_of_order;
    complete(5, 2);
    complete(0, -1);
    read_check(5'd5, 5'd2);
    complete(3, 1);
    complete(4, -1);
    read_check(5'd0, 5'd4);
    drain();
  endtask

  // fills to 31 entries, so the tags wrap from 31 to 0
  task automatic test_full_stall;
    int n;
    for (n = 0; n < 31 && !hung; n++)
      dispatch(2'b01);
    #1;
    check("dispatch_ready when full", 64'(dispatch_ready), 64'd0);
    next_cycle();
    for (n = 30; n > 0; n -= 2)
      complete(int'(order_q[n]), int'(order_q[n-1]));
    complete(int'(order_q[0]), -1);
    for (n = 0; n < 4; n++)
    begin
      #1;
      check_commit(1'b0);
      check("dispatch_ready while stalled", 64'(dispatch_ready), 64'd0);
      next_cycle();
    end
    retire_ready = 1'b1;
    #1;
    check_commit(1'b1);
    next_cycle();
    retire_ready = 1'b0;
    #1;
    check("dispatch_ready after retire", 64'(dispatch_ready), 64'd1);
    next_cycle();
    drain();
  endtask

  initial
  begin
    void'($urandom(32'h6862_fcb4));
    errors = 0;
    checks = 0;
    hung = 1'b0;
    next_tag = 5'd0;
    reset = 1'b1;
    dispatch_valid = 2'b00;
    dispatch_dest0 = 5'd0;
    dispatch_dest1 = 5'd0;
    cdb0_tag.raw = rob_pkg::tag_null;
    cdb1_tag.raw = rob_pkg::tag_null;
    cdb0_value = 64'd0;
    cdb1_value = 64'd0;
    read_tag0.raw = 8'd0;
    read_tag1.raw = 8'd0;
    retire_ready = 1'b0;
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;

    test_reset();
    if (!hung)
      test_tag_order();
    if (!hung)
      test_out_of_order();
    if (!hung)
      test_full_stall();

    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule
